// File: hw/board_reg_bank.sv
// Board register bank
`default_nettype none

module board_reg_bank #(
    parameter int ADDR_BITS    = 6,
    parameter int READ_LATENCY = 2
) (
    input  logic               sysclk,
    input  logic               arst_n,
    input  logic               req_read_bus,
    output logic               grant_read_bus,
    input  logic               req_write_bus,
    output logic               grant_write_bus,
    input  emio_pkg::reg_bus_t bus,
    output logic [31:0]        rdata,
    output logic               rvalid
);
    import emio_pkg::*;

    localparam int DEPTH = 2 ** ADDR_BITS;

    logic [31:0]             mem [DEPTH];
    logic [ADDR_BITS-1:0]    widx;
    logic                    mapped;
    // address seen last cycle, for change detection
    logic [15:0]             addr_q;
    // read valid delay line
    logic [READ_LATENCY-1:0] vld_sh;
    logic                    restart;

    assign widx    = bus.addr[ADDR_BITS-1:0];
    // only the main page is backed by storage
    assign mapped  = (bus.addr[15:12] == ADDR_MAIN);
    assign restart = ~grant_read_bus | (bus.addr != addr_q);

    // grant follows the request by one cycle
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            grant_read_bus  <= 1'b0;
            grant_write_bus <= 1'b0;
        end else begin
            grant_read_bus  <= req_read_bus;
            grant_write_bus <= req_write_bus;
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.wen && mapped) begin
            mem[widx] <= bus.wdata;
        end
    end

    // unmapped pages read as all ones
    always_ff @(posedge sysclk) begin
        rdata <= mapped ? mem[widx] : UNMAPPED_DATA;
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
            vld_sh <= '0;
        end else begin
            addr_q <= bus.addr;
            if (restart) begin
                vld_sh <= '0;
            end else begin
                vld_sh <= (vld_sh << 1) | READ_LATENCY'(1);
            end
        end
    end

    // an address change hides stale data right away
    assign rvalid = vld_sh[READ_LATENCY-1] & (bus.addr == addr_q);

endmodule

`default_nettype wire

// File: hw/emio_bridge_top.sv
// EMIO bridge top level
`default_nettype none

module emio_bridge_top #(
    parameter int ADDR_BITS    = 6,
    parameter int READ_LATENCY = 2
) (
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic [63:0] emio_ps_out,
    input  logic [63:0] emio_ps_tri,
    output logic [63:0] emio_ps_in
);
    import emio_pkg::*;

    ps_cmd_t     cmd;
    logic        req_rise;
    logic        req_fall;
    logic        req_read_bus;
    logic        grant_read_bus;
    logic        req_write_bus;
    logic        grant_write_bus;
    reg_bus_t    bus;
    logic [31:0] rdata;
    logic        rvalid;
    logic [31:0] rdata_latched;
    logic        op_done;

    // stage 1, pins into sysclk domain
    emio_cmd_sync u_sync (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .ps_out      (emio_ps_out),
        .ps_tri_data (emio_ps_tri[31:0]),
        .cmd         (cmd),
        .req_rise    (req_rise),
        .req_fall    (req_fall)
    );

    // stage 2, transfer FSM
    emio_xfer_ctrl #(
        .ADDR_BITS (ADDR_BITS)
    ) u_ctrl (
        .sysclk          (sysclk),
        .arst_n          (arst_n),
        .cmd             (cmd),
        .req_rise        (req_rise),
        .req_fall        (req_fall),
        .req_read_bus    (req_read_bus),
        .grant_read_bus  (grant_read_bus),
        .req_write_bus   (req_write_bus),
        .grant_write_bus (grant_write_bus),
        .bus             (bus),
        .rdata           (rdata),
        .rvalid          (rvalid),
        .rdata_latched   (rdata_latched),
        .op_done         (op_done)
    );

    // stage 3, registers
    board_reg_bank #(
        .ADDR_BITS    (ADDR_BITS),
        .READ_LATENCY (READ_LATENCY)
    ) u_bank (
        .sysclk          (sysclk),
        .arst_n          (arst_n),
        .req_read_bus    (req_read_bus),
        .grant_read_bus  (grant_read_bus),
        .req_write_bus   (req_write_bus),
        .grant_write_bus (grant_write_bus),
        .bus             (bus),
        .rdata           (rdata),
        .rvalid          (rvalid)
    );

    // status word back to the processor, bits 59 to 55 unused
    always_comb begin
        emio_ps_in = '0;
        emio_ps_in[EMIO_VER_MSB:EMIO_VER_LSB] = EMIO_VERSION;
        // grant of the bus matching the current direction
        emio_ps_in[EMIO_GRANT_BIT] = cmd.write ? grant_write_bus : grant_read_bus;
        emio_ps_in[EMIO_WRITE_BIT] = cmd.write;
        emio_ps_in[EMIO_BLK_END_BIT] = cmd.blk_end;
        emio_ps_in[EMIO_BLK_START_BIT] = cmd.blk_start;
        emio_ps_in[EMIO_WEN_BIT] = cmd.wen_hint;
        emio_ps_in[EMIO_DONE_BIT] = op_done;
        emio_ps_in[EMIO_REQ_BIT] = cmd.req;
        emio_ps_in[EMIO_ADDR_MSB:EMIO_ADDR_LSB] = cmd.addr;
        // write echoes the processor data, read shows the latched word
        emio_ps_in[EMIO_DATA_MSB:EMIO_DATA_LSB] = cmd.write ? cmd.wdata : rdata_latched;
    end

endmodule

`default_nettype wire

// File: hw/emio_cmd_sync.sv
// EMIO command synchronizer
`default_nettype none

module emio_cmd_sync (
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic [63:0]       ps_out,
    input  logic [31:0]       ps_tri_data,
    output emio_pkg::ps_cmd_t cmd,
    output logic              req_rise,
    output logic              req_fall
);
    import emio_pkg::*;

    // command fields straight off the pins, not yet in sysclk domain
    ps_cmd_t cmd_raw;
    // two-flop synchronizer for req
    logic    req_s1;
    logic    req_s2;
    // edge register behind the synchronizer
    logic    req_d;

    always_comb begin
        cmd_raw.wdata     = ps_out[EMIO_DATA_MSB:EMIO_DATA_LSB];
        cmd_raw.addr      = ps_out[EMIO_ADDR_MSB:EMIO_ADDR_LSB];
        cmd_raw.req       = ps_out[EMIO_REQ_BIT];
        cmd_raw.wen_hint  = ps_out[EMIO_WEN_BIT];
        cmd_raw.blk_start = ps_out[EMIO_BLK_START_BIT];
        cmd_raw.blk_end   = ps_out[EMIO_BLK_END_BIT];
        // data lines all driven by the processor means write
        cmd_raw.write     = (ps_tri_data == '0);
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd    <= '0;
            req_s1 <= 1'b0;
            req_s2 <= 1'b0;
            req_d  <= 1'b0;
        end else begin
            // fields are stable long before the synchronized req edge arrives
            cmd    <= cmd_raw;
            req_s1 <= ps_out[EMIO_REQ_BIT];
            req_s2 <= req_s1;
            req_d  <= req_s2;
        end
    end

    assign req_rise = req_s2 & ~req_d;
    assign req_fall = ~req_s2 & req_d;

endmodule

`default_nettype wire

// File: hw/emio_pkg.sv
// EMIO bridge definitions
`default_nettype none

package emio_pkg;

    // processor command as seen on the EMIO output word
    typedef struct packed {
        logic [31:0] wdata;
        logic [15:0] addr;
        logic        req;
        // echoed back only
        logic        wen_hint;
        logic        blk_start;
        logic        blk_end;
        // set when no data line is tristated
        logic        write;
    } ps_cmd_t;

    // register bus request toward the bank
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] wdata;
        logic        wen;
        // last write of a transfer
        logic        blk_wen;
    } reg_bus_t;

    localparam logic [3:0]  EMIO_VERSION  = 4'd1;
    // page decoded by the bank, bits 15 to 12
    localparam logic [3:0]  ADDR_MAIN     = 4'd0;
    localparam logic [31:0] UNMAPPED_DATA = 32'hffff_ffff;

    // field positions in the EMIO words
    localparam int EMIO_DATA_LSB      = 0;
    localparam int EMIO_DATA_MSB      = 31;
    localparam int EMIO_ADDR_LSB      = 32;
    localparam int EMIO_ADDR_MSB      = 47;
    localparam int EMIO_REQ_BIT       = 48;
    localparam int EMIO_DONE_BIT      = 49;
    localparam int EMIO_WEN_BIT       = 50;
    localparam int EMIO_BLK_START_BIT = 51;
    localparam int EMIO_BLK_END_BIT   = 52;
    localparam int EMIO_WRITE_BIT     = 53;
    localparam int EMIO_GRANT_BIT     = 54;
    localparam int EMIO_VER_LSB       = 60;
    localparam int EMIO_VER_MSB       = 63;

endpackage

`default_nettype wire

// File: hw/emio_xfer_ctrl.sv
// EMIO transfer controller
`default_nettype none

module emio_xfer_ctrl #(
    parameter int ADDR_BITS = 6
) (
    input  logic               sysclk,
    input  logic               arst_n,
    input  emio_pkg::ps_cmd_t  cmd,
    input  logic               req_rise,
    input  logic               req_fall,
    output logic               req_read_bus,
    input  logic               grant_read_bus,
    output logic               req_write_bus,
    input  logic               grant_write_bus,
    output emio_pkg::reg_bus_t bus,
    input  logic [31:0]        rdata,
    input  logic               rvalid,
    output logic [31:0]        rdata_latched,
    output logic               op_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE_QUAD,
        ST_WRITE_BLOCK_START,
        ST_WRITE_BLOCK_DATA,
        ST_WRITE_FINISH
    } state_t;

    state_t      state;
    // own copy of the transfer address, stepped for block transfers
    logic [15:0] addr_q;
    // bit 0 of the last address taken from the processor
    logic        addr_lsb;
    logic [31:0] wdata_q;
    logic        wen_q;
    logic        blk_wen_q;
    logic        done_q;
    logic        rvalid_q;
    // current block quadlet carries blk_end
    logic        last_q;
    // cycles since the last block write enable
    logic [1:0]  blk_cnt;

    logic        lsb_equal;
    logic        addr_next;
    logic        read_grant;
    logic        write_grant;
    logic [15:0] addr_step;

    assign lsb_equal   = (cmd.addr[0] == addr_lsb);
    // processor toggled bit 0, next quadlet of a block
    assign addr_next   = ~lsb_equal;
    assign read_grant  = req_read_bus & grant_read_bus;
    assign write_grant = req_write_bus & grant_write_bus;

    // word index wraps inside the bank, page bits are kept
    always_comb begin
        addr_step = addr_q;
        addr_step[ADDR_BITS-1:0] = addr_q[ADDR_BITS-1:0] + ADDR_BITS'(1);
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_IDLE;
            addr_q        <= '0;
            addr_lsb      <= 1'b0;
            wdata_q       <= '0;
            wen_q         <= 1'b0;
            blk_wen_q     <= 1'b0;
            done_q        <= 1'b0;
            rvalid_q      <= 1'b0;
            last_q        <= 1'b0;
            blk_cnt       <= '0;
            req_read_bus  <= 1'b0;
            req_write_bus <= 1'b0;
            rdata_latched <= '0;
        end else begin
            rvalid_q <= rvalid;
            case (state)
                ST_IDLE: begin
                    done_q    <= 1'b0;
                    wen_q     <= 1'b0;
                    blk_wen_q <= 1'b0;
                    blk_cnt   <= '0;
                    if (req_rise) begin
                        addr_q   <= cmd.addr;
                        addr_lsb <= cmd.addr[0];
                        wdata_q  <= cmd.wdata;
                        last_q   <= cmd.blk_end;
                        if (cmd.write) begin
                            req_write_bus <= 1'b1;
                            req_read_bus  <= 1'b0;
                            state <= cmd.blk_start ? ST_WRITE_BLOCK_START : ST_WRITE_QUAD;
                        end else begin
                            req_read_bus  <= 1'b1;
                            req_write_bus <= 1'b0;
                            state         <= ST_READ;
                        end
                    end else begin
                        // release both buses while nothing is pending
                        req_read_bus  <= 1'b0;
                        req_write_bus <= 1'b0;
                    end
                end
                ST_READ: begin
                    // read bus is kept until the processor drops req
                    if (read_grant) begin
                        if (addr_next) begin
                            addr_q   <= addr_step;
                            addr_lsb <= cmd.addr[0];
                            done_q   <= 1'b0;
                        end else if (rvalid && rvalid_q) begin
                            // rvalid seen stable for two cycles
                            rdata_latched <= rdata;
                            done_q        <= 1'b1;
                        end
                    end
                end
                ST_WRITE_QUAD: begin
                    // address and data already on the bus
                    if (write_grant) begin
                        wen_q     <= 1'b1;
                        blk_wen_q <= 1'b1;
                        state     <= ST_WRITE_FINISH;
                    end
                end
                ST_WRITE_BLOCK_START: begin
                    // first quadlet goes out as soon as the bus is ours
                    if (write_grant) begin
                        wen_q     <= 1'b1;
                        blk_wen_q <= last_q;
                        blk_cnt   <= '0;
                        state     <= ST_WRITE_BLOCK_DATA;
                    end
                end
                ST_WRITE_BLOCK_DATA: begin
                    if (write_grant) begin
                        if (addr_next) begin
                            // new quadlet, write it in the same step
                            addr_q    <= addr_step;
                            addr_lsb  <= cmd.addr[0];
                            wdata_q   <= cmd.wdata;
                            last_q    <= cmd.blk_end;
                            wen_q     <= 1'b1;
                            blk_wen_q <= cmd.blk_end;
                            done_q    <= 1'b0;
                            blk_cnt   <= '0;
                        end else begin
                            wen_q     <= 1'b0;
                            blk_wen_q <= 1'b0;
                            if (last_q) begin
                                state <= ST_WRITE_FINISH;
                            end else if (blk_cnt == 2'd1) begin
                                // two cycles after the write enable
                                done_q <= 1'b1;
                            end
                            // counter saturates at 2
                            if (blk_cnt != 2'd2) begin
                                blk_cnt <= blk_cnt + 2'd1;
                            end
                        end
                    end else begin
                        // lost the bus, start the done delay over
                        blk_cnt <= '0;
                    end
                end
                ST_WRITE_FINISH: begin
                    wen_q         <= 1'b0;
                    blk_wen_q     <= 1'b0;
                    req_write_bus <= 1'b0;
                    done_q        <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
            // falling req aborts anything and ends read and finish states
            if (req_fall) begin
                state         <= ST_IDLE;
                done_q        <= 1'b0;
                wen_q         <= 1'b0;
                blk_wen_q     <= 1'b0;
                req_read_bus  <= 1'b0;
                req_write_bus <= 1'b0;
            end
        end
    end

    assign bus = '{addr: addr_q, wdata: wdata_q, wen: wen_q, blk_wen: blk_wen_q};

    // done only counts once the processor's address bit 0 matches ours
    assign op_done = done_q & lsb_equal;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module emio_bridge_tb -f src.f

out=$(./obj_dir/Vemio_bridge_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^TEST PASSED$'; then
    exit 0
fi
exit 1

// File: src.f
hw/emio_pkg.sv
hw/emio_cmd_sync.sv
hw/emio_xfer_ctrl.sv
hw/board_reg_bank.sv
hw/emio_bridge_top.sv
test/emio_bridge_properties.sv
test/emio_bridge_tb.sv

// File: test/emio_bridge_properties.sv
// Transfer controller assertions
`default_nettype none

module emio_bridge_properties (
    input logic               sysclk,
    input logic               arst_n,
    input logic               req_read_bus,
    input logic               req_write_bus,
    input logic               grant_write_bus,
    input emio_pkg::reg_bus_t bus,
    input logic               req_fall,
    input logic               op_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // only one bus requested at a time
    a_single_request: assert property (
        @(posedge sysclk) disable iff (!arst_n) !(req_read_bus && req_write_bus)
    ) else $error("read and write bus requested together");

    // a write enable only goes out on a granted write bus
    a_wen_granted: assert property (
        @(posedge sysclk) disable iff (!arst_n) bus.wen |-> grant_write_bus
    ) else $error("write enable without write grant");

    // abort or end of transfer clears done
    a_done_after_fall: assert property (
        @(posedge sysclk) disable iff (!arst_n) req_fall |=> !op_done
    ) else $error("done still high after request fall");

endmodule

bind emio_xfer_ctrl emio_bridge_properties props (
    .sysclk          (sysclk),
    .arst_n          (arst_n),
    .req_read_bus    (req_read_bus),
    .req_write_bus   (req_write_bus),
    .grant_write_bus (grant_write_bus),
    .bus             (bus),
    .req_fall        (req_fall),
    .op_done         (op_done)
);

`default_nettype wire

// File: test/emio_bridge_tb.sv
// EMIO bridge testbench
`default_nettype none

module emio_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import emio_pkg::*;

    localparam int ADDR_BITS      = 6;
    localparam int READ_LATENCY   = 2;
    localparam int DEPTH          = 2 ** ADDR_BITS;
    localparam int CLK_HALF       = 50;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_XACTS      = 10;
    // bridge revision reported in the top nibble of the status word
    localparam logic [3:0]  EXP_VERSION   = 4'd1;
    // page backed by the bank, address bits 15 to 12
    localparam logic [3:0]  MAIN_PAGE     = 4'h0;
    localparam logic [31:0] UNMAPPED_WORD = 32'hffff_ffff;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BLK_WRITE, OP_BLK_READ} op_t;

    // one processor transaction
    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        int          len;
        logic        abort;
        logic [31:0] exp_data;
    } xact_t;

    logic        sysclk;
    logic        arst_n;
    logic [63:0] emio_ps_out;
    logic [63:0] emio_ps_tri;
    logic [63:0] emio_ps_in;
    logic [31:0] lfsr;
    // shadow copy of the main page
    logic [31:0] shadow [DEPTH];

    // expected data of quadlet reads is filled from the shadow as each entry runs
    xact_t xacts [NUM_XACTS] = '{
        '{OP_WRITE,     16'h0010, 1, 1'b0, 32'h0},
        '{OP_READ,      16'h0010, 1, 1'b0, 32'h0},
        // block wraps past the top of the bank
        '{OP_BLK_WRITE, 16'h003d, 4, 1'b0, 32'h0},
        '{OP_BLK_READ,  16'h003d, 4, 1'b0, 32'h0},
        '{OP_READ,      16'h3004, 1, 1'b0, 32'h0},
        '{OP_WRITE,     16'h3004, 1, 1'b0, 32'h0},
        '{OP_READ,      16'h0004, 1, 1'b0, 32'h0},
        '{OP_READ,      16'h0010, 1, 1'b1, 32'h0},
        '{OP_WRITE,     16'h0011, 1, 1'b0, 32'h0},
        '{OP_READ,      16'h0011, 1, 1'b0, 32'h0}
    };

    emio_bridge_top #(
        .ADDR_BITS    (ADDR_BITS),
        .READ_LATENCY (READ_LATENCY)
    ) dut (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .emio_ps_out (emio_ps_out),
        .emio_ps_tri (emio_ps_tri),
        .emio_ps_in  (emio_ps_in)
    );

    initial begin
        sysclk = 1'b0;
        forever begin
            #CLK_HALF sysclk = ~sysclk;
        end
    end

    // fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit of the word
    task automatic next_rand_word(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            word = {word[30:0], lfsr[0]};
        end
    endtask

    // word index wraps, page bits stay
    function automatic logic [15:0] block_addr(input logic [15:0] base, input int k);
        return {base[15:ADDR_BITS], base[ADDR_BITS-1:0] + ADDR_BITS'(k)};
    endfunction

    function automatic logic [31:0] model_read(input logic [15:0] addr);
        return (addr[15:12] == MAIN_PAGE) ? shadow[addr[ADDR_BITS-1:0]] : UNMAPPED_WORD;
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [31:0] data);
        if (addr[15:12] == MAIN_PAGE) begin
            shadow[addr[ADDR_BITS-1:0]] = data;
        end
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    task automatic wait_status(input int pos, input logic value, input string what);
        int cycles;
        cycles = 0;
        while (emio_ps_in[pos] !== value && cycles < TIMEOUT_CYCLES) begin
            @(negedge sysclk);
            cycles++;
        end
        if (emio_ps_in[pos] !== value) begin
            stop_on_error($sformatf("timeout after %0d cycles waiting for %s",
                                    TIMEOUT_CYCLES, what));
        end
    endtask

    // wen hint follows the direction, read tristates the data lines
    task automatic drive_cmd(input logic write, input logic [15:0] addr,
                             input logic [31:0] data, input logic blk_start,
                             input logic blk_end, input logic req);
        emio_ps_out = '0;
        emio_ps_out[EMIO_DATA_MSB:EMIO_DATA_LSB] = data;
        emio_ps_out[EMIO_ADDR_MSB:EMIO_ADDR_LSB] = addr;
        emio_ps_out[EMIO_REQ_BIT] = req;
        emio_ps_out[EMIO_WEN_BIT] = write;
        emio_ps_out[EMIO_BLK_START_BIT] = blk_start;
        emio_ps_out[EMIO_BLK_END_BIT] = blk_end;
        emio_ps_tri = write ? 64'h0 : 64'h0000_0000_ffff_ffff;
    endtask

    // drop req, then bridge back to idle with the bus released
    task automatic finish_xfer();
        emio_ps_out[EMIO_REQ_BIT] = 1'b0;
        wait_status(EMIO_DONE_BIT, 1'b0, "done to fall after req drop");
        wait_status(EMIO_GRANT_BIT, 1'b0, "bus release after req drop");
    endtask

    task automatic quad_write(input logic [15:0] addr);
        logic [31:0] word;
        next_rand_word(word);
        model_write(addr, word);
        drive_cmd(1'b1, addr, word, 1'b0, 1'b0, 1'b1);
        wait_status(EMIO_GRANT_BIT, 1'b1, "write grant");
        check("done while write bus held", 64'(emio_ps_in[EMIO_DONE_BIT]), 64'h0);
        wait_status(EMIO_DONE_BIT, 1'b1, "write done");
        // write, blk flags, wen hint, done, req, addr
        check("echo[53:32]", 64'(emio_ps_in[53:32]), 64'({1'b1, 2'b00, 1'b1, 2'b11, addr}));
        check("data[31:0]", 64'(emio_ps_in[31:0]), 64'(word));
        finish_xfer();
    endtask

    task automatic quad_read(input logic [15:0] addr, input logic [31:0] exp_data);
        drive_cmd(1'b0, addr, 32'h0, 1'b0, 1'b0, 1'b1);
        wait_status(EMIO_DONE_BIT, 1'b1, "read done");
        check("data[31:0]", 64'(emio_ps_in[31:0]), 64'(exp_data));
        check("echo[53:32]", 64'(emio_ps_in[53:32]), 64'({1'b0, 2'b00, 1'b0, 2'b11, addr}));
        // read bus stays granted until req drops
        check("grant after read done", 64'(emio_ps_in[EMIO_GRANT_BIT]), 64'h1);
        finish_xfer();
    endtask

    task automatic aborted_read(input logic [15:0] addr);
        drive_cmd(1'b0, addr, 32'h0, 1'b0, 1'b0, 1'b1);
        wait_status(EMIO_GRANT_BIT, 1'b1, "read grant before abort");
        check("done before abort", 64'(emio_ps_in[EMIO_DONE_BIT]), 64'h0);
        emio_ps_out[EMIO_REQ_BIT] = 1'b0;
        // done must never show up for the dropped read
        repeat (12) begin
            @(negedge sysclk);
            check("done after abort", 64'(emio_ps_in[EMIO_DONE_BIT]), 64'h0);
        end
        wait_status(EMIO_GRANT_BIT, 1'b0, "read bus release after abort");
    endtask

    // processor toggles bit 0 per quadlet, bridge steps its own address
    task automatic block_xfer(input logic write, input logic [15:0] base, input int len);
        logic [31:0] word;
        logic [15:0] pin_addr;
        logic        last;
        for (int k = 0; k < len; k++) begin
            word = 32'h0;
            last = (k == len - 1);
            if (write) begin
                next_rand_word(word);
                model_write(block_addr(base, k), word);
            end
            pin_addr = base;
            pin_addr[0] = base[0] ^ k[0];
            drive_cmd(write, pin_addr, word, 1'b1, last, 1'b1);
            if (k > 0) begin
                wait_status(EMIO_DONE_BIT, 1'b0, "done to fall on next quadlet");
            end
            wait_status(EMIO_DONE_BIT, 1'b1, "block quadlet done");
            // blk_end only on the last quadlet, blk_start on all of them
            check($sformatf("block echo[53:32] quadlet %0d", k),
                  64'(emio_ps_in[53:32]),
                  64'({write, last, 1'b1, write, 2'b11, pin_addr}));
            if (!write) begin
                check($sformatf("block data[31:0] quadlet %0d", k),
                      64'(emio_ps_in[31:0]), 64'(model_read(block_addr(base, k))));
            end
        end
        finish_xfer();
    endtask

    task automatic run_xact(input xact_t x);
        case (x.op)
            OP_WRITE: quad_write(x.addr);
            OP_READ: begin
                if (x.abort) begin
                    aborted_read(x.addr);
                end else begin
                    quad_read(x.addr, x.exp_data);
                end
            end
            OP_BLK_WRITE: block_xfer(1'b1, x.addr, x.len);
            OP_BLK_READ: block_xfer(1'b0, x.addr, x.len);
            default: stop_on_error("unknown operation in transaction table");
        endcase
    endtask

    initial begin
        arst_n      = 1'b0;
        emio_ps_out = '0;
        emio_ps_tri = '0;
        lfsr        = 32'h44be;
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = 32'h0;
        end
        repeat (8) @(negedge sysclk);
        arst_n = 1'b1;
        @(negedge sysclk);

        // idle status after reset
        check("done after reset", 64'(emio_ps_in[EMIO_DONE_BIT]), 64'h0);
        check("version", 64'(emio_ps_in[EMIO_VER_MSB:EMIO_VER_LSB]), 64'(EXP_VERSION));
        check("grant after reset", 64'(emio_ps_in[EMIO_GRANT_BIT]), 64'h0);

        for (int i = 0; i < NUM_XACTS; i++) begin
            if (xacts[i].op == OP_READ) begin
                xacts[i].exp_data = model_read(xacts[i].addr);
            end
            run_xact(xacts[i]);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
